// ==== design/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // bit positions inside a 32-bit instruction word
    localparam int unsigned OPCODE_MSB = 31;
    localparam int unsigned OPCODE_LSB = 26;
    localparam int unsigned RS_MSB     = 25;
    localparam int unsigned RS_LSB     = 21;
    localparam int unsigned RT_MSB     = 20;
    localparam int unsigned RT_LSB     = 16;
    localparam int unsigned RD_MSB     = 15;
    localparam int unsigned RD_LSB     = 11;
    localparam int unsigned SHAMT_MSB  = 10;
    localparam int unsigned SHAMT_LSB  = 6;
    localparam int unsigned FUNCT_MSB  = 5;
    localparam int unsigned FUNCT_LSB  = 0;
    localparam int unsigned IMM_MSB    = 15;
    localparam int unsigned IMM_LSB    = 0;

    // primary opcodes handled by the decode stage
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,   // register forms selected by funct
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,   // shamt forms
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,   // shift by rs
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    localparam int unsigned WORD_W     = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation subtype handed to EX
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } aluop_t;

    // result class picking the EX result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_t;

    // register write from EX, MEM or write-back
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;           // destination register
        logic      wreg;
        logic      inst_valid;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t ctrl;
        word_t    reg1;
        word_t    reg2;
    } id_ex_t;

    typedef struct packed {
        logic      re;
        reg_addr_t addr;
    } rd_req_t;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  pipe_pkg::reg_write_t wb_i,
    input  pipe_pkg::rd_req_t    rd1_i,
    input  pipe_pkg::rd_req_t    rd2_i,
    output pipe_pkg::word_t      rd1_data_o,
    output pipe_pkg::word_t      rd2_data_o
);
    import pipe_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin   // $zero never written
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // same read rules on both ports
    function automatic word_t read_port(rd_req_t req, reg_write_t wb, word_t stored);
        if (!req.re || (req.addr == '0)) begin
            return '0;
        end else if (wb.we && (wb.addr == req.addr)) begin
            return wb.data;                               // write-through
        end else begin
            return stored;
        end
    endfunction

    assign rd1_data_o = read_port(rd1_i, wb_i, regs[rd1_i.addr]);
    assign rd2_data_o = read_port(rd2_i, wb_i, regs[rd2_i.addr]);

endmodule

// ==== design/id_decoder.sv ====
`timescale 1ns/10ps

module id_decoder (
    input  logic [31:0]        inst_i,
    output pipe_pkg::id_ctrl_t ctrl_o,
    output pipe_pkg::rd_req_t  rd1_o,
    output pipe_pkg::rd_req_t  rd2_o,
    output pipe_pkg::word_t    imm_o
);
    import pipe_pkg::*;
    import mips_isa_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    aluop_t    fn_aluop;
    aluop_t    op_aluop;
    logic      shamt_form;

    assign opcode = opcode_e'(inst_i[OPCODE_MSB:OPCODE_LSB]);
    assign funct  = funct_e'(inst_i[FUNCT_MSB:FUNCT_LSB]);
    assign rs     = inst_i[RS_MSB:RS_LSB];
    assign rt     = inst_i[RT_MSB:RT_LSB];
    assign rd     = inst_i[RD_MSB:RD_LSB];
    assign shamt  = inst_i[SHAMT_MSB:SHAMT_LSB];
    assign imm16  = inst_i[IMM_MSB:IMM_LSB];

    assign shamt_form = funct inside {FN_SLL, FN_SRL, FN_SRA};

    function automatic alusel_t sel_of(aluop_t op);
        case (op)
            ALU_NOP:                          return SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:        return SEL_SHIFT;
            default:                          return SEL_ARITH;
        endcase
    endfunction

    // SPECIAL funct table
    always_comb begin
        case (funct)
            FN_OR:           fn_aluop = ALU_OR;
            FN_AND:          fn_aluop = ALU_AND;
            FN_XOR:          fn_aluop = ALU_XOR;
            FN_NOR:          fn_aluop = ALU_NOR;
            FN_SLL, FN_SLLV: fn_aluop = ALU_SLL;
            FN_SRL, FN_SRLV: fn_aluop = ALU_SRL;
            FN_SRA, FN_SRAV: fn_aluop = ALU_SRA;
            FN_ADD:          fn_aluop = ALU_ADD;
            FN_ADDU:         fn_aluop = ALU_ADDU;
            FN_SUB:          fn_aluop = ALU_SUB;
            FN_SUBU:         fn_aluop = ALU_SUBU;
            FN_SLT:          fn_aluop = ALU_SLT;
            FN_SLTU:         fn_aluop = ALU_SLTU;
            default:         fn_aluop = ALU_NOP;
        endcase
    end

    // I-type opcode table
    always_comb begin
        case (opcode)
            OP_ORI:   op_aluop = ALU_OR;
            OP_ANDI:  op_aluop = ALU_AND;
            OP_XORI:  op_aluop = ALU_XOR;
            OP_LUI:   op_aluop = ALU_OR;     // rs | (imm << 16)
            OP_ADDI:  op_aluop = ALU_ADDI;
            OP_ADDIU: op_aluop = ALU_ADDIU;
            OP_SLTI:  op_aluop = ALU_SLT;
            OP_SLTIU: op_aluop = ALU_SLTU;
            default:  op_aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        ctrl_o.aluop = ALU_NOP;
        ctrl_o.wd    = rd;
        rd1_o.re     = 1'b0;
        rd1_o.addr   = rs;
        rd2_o.re     = 1'b0;
        rd2_o.addr   = rt;
        imm_o        = '0;

        case (opcode)
            OP_SPECIAL: begin
                if (shamt_form) begin
                    if (rs == '0) begin              // inst[31:21] all zero
                        ctrl_o.aluop = fn_aluop;
                        rd2_o.re     = 1'b1;
                        imm_o        = {27'b0, shamt};
                    end
                end else if ((shamt == '0) && (fn_aluop != ALU_NOP)) begin
                    ctrl_o.aluop = fn_aluop;
                    rd1_o.re     = 1'b1;
                    rd2_o.re     = 1'b1;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                ctrl_o.aluop = op_aluop;
                ctrl_o.wd    = rt;
                rd1_o.re     = 1'b1;
                imm_o        = {16'b0, imm16};
            end
            OP_LUI: begin
                ctrl_o.aluop = op_aluop;
                ctrl_o.wd    = rt;
                rd1_o.re     = 1'b1;
                imm_o        = {imm16, 16'b0};
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl_o.aluop = op_aluop;
                ctrl_o.wd    = rt;
                rd1_o.re     = 1'b1;
                imm_o        = {{16{imm16[15]}}, imm16};
            end
            default: begin
            end
        endcase

        // every kept instruction writes a register
        ctrl_o.alusel     = sel_of(ctrl_o.aluop);
        ctrl_o.wreg       = (ctrl_o.aluop != ALU_NOP);
        ctrl_o.inst_valid = (ctrl_o.aluop != ALU_NOP);
    end

endmodule

// ==== design/operand_select.sv ====
`timescale 1ns/10ps

module operand_select (
    input  pipe_pkg::rd_req_t    rd_i,
    input  pipe_pkg::word_t      rf_data_i,
    input  pipe_pkg::word_t      imm_i,
    input  pipe_pkg::reg_write_t ex_fwd_i,
    input  pipe_pkg::reg_write_t mem_fwd_i,
    output pipe_pkg::word_t      operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = rd_i.re && ex_fwd_i.we && (ex_fwd_i.addr == rd_i.addr);
    assign mem_hit = rd_i.re && mem_fwd_i.we && (mem_fwd_i.addr == rd_i.addr);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_fwd_i.data;      // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else if (rd_i.re) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [31:0]          inst_i,
    input  pipe_pkg::reg_write_t ex_fwd_i,
    input  pipe_pkg::reg_write_t mem_fwd_i,
    output pipe_pkg::rd_req_t    rd1_o,
    output pipe_pkg::rd_req_t    rd2_o,
    input  pipe_pkg::word_t      rf_data1_i,
    input  pipe_pkg::word_t      rf_data2_i,
    output pipe_pkg::id_ex_t     id_ex_o
);
    import pipe_pkg::*;

    id_ctrl_t ctrl;
    word_t    imm;
    word_t    op1;
    word_t    op2;

    id_decoder id_decoder_inst (
        .inst_i (inst_i),
        .ctrl_o (ctrl),
        .rd1_o  (rd1_o),
        .rd2_o  (rd2_o),
        .imm_o  (imm)
    );

    operand_select op1_select_inst (
        .rd_i      (rd1_o),
        .rf_data_i (rf_data1_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_select op2_select_inst (
        .rd_i      (rd2_o),
        .rf_data_i (rf_data2_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;                  // NOP with no write
        end else begin
            id_ex_o <= '{ctrl: ctrl, reg1: op1, reg2: op2};
        end
    end

endmodule

// ==== design/decode_unit_top.sv ====
`timescale 1ns/10ps

module decode_unit_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [31:0]          inst_i,
    input  pipe_pkg::reg_write_t ex_fwd_i,
    input  pipe_pkg::reg_write_t mem_fwd_i,
    input  pipe_pkg::reg_write_t wb_i,
    output pipe_pkg::id_ex_t     id_ex_o
);
    import pipe_pkg::*;

    rd_req_t rd1;
    rd_req_t rd2;
    word_t   rf_data1;
    word_t   rf_data2;

    regfile regfile_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_i       (wb_i),
        .rd1_i      (rd1),
        .rd2_i      (rd2),
        .rd1_data_o (rf_data1),
        .rd2_data_o (rf_data2)
    );

    id_stage id_stage_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .inst_i     (inst_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .rd1_o      (rd1),
        .rd2_o      (rd2),
        .rf_data1_i (rf_data1),
        .rf_data2_i (rf_data2),
        .id_ex_o    (id_ex_o)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                     // released away from the sampling edge
    end

endmodule

// ==== tests/decode_unit_chk.sv ====
`timescale 1ns/10ps

module decode_unit_chk (
    input logic             clk_i,
    input logic             rst_n_i,
    input pipe_pkg::id_ex_t id_ex_i
);
    import pipe_pkg::*;

    int unsigned fail_count = 0;

    reset_clears: assert property (@(posedge clk_i)
        !rst_n_i |=> !id_ex_i.ctrl.wreg && !id_ex_i.ctrl.inst_valid)
    else begin
        fail_count++;
        $error("ID/EX write enable or inst_valid set after a reset edge");
    end

    invalid_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !id_ex_i.ctrl.inst_valid |-> !id_ex_i.ctrl.wreg)
    else begin
        fail_count++;
        $error("invalid instruction carries a register write");
    end

    nop_pairing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (id_ex_i.ctrl.alusel == SEL_NOP) == (id_ex_i.ctrl.aluop == ALU_NOP))
    else begin
        fail_count++;
        $error("alusel NOP and aluop NOP disagree");
    end

endmodule

bind id_stage decode_unit_chk decode_unit_chk_inst (
    .clk_i   (clk),
    .rst_n_i (rst_n_i),
    .id_ex_i (id_ex_o)
);

// ==== tests/tb_decode_unit.sv ====
`timescale 1ns/10ps

module tb_decode_unit;
    import pipe_pkg::*;
    import mips_isa_pkg::*;

    localparam int unsigned NUM_TESTS    = 400;
    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned PERIOD_NS    = 100;

    localparam logic [5:0] REG_FUNCTS [13] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    localparam logic [5:0] SHIFT_FUNCTS [3] = '{FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] IMM_OPS [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
    localparam logic [5:0] BAD_FUNCTS [6] = '{6'h18, 6'h19, 6'h10, 6'h0a, 6'h0b, 6'h0f};
    localparam logic [5:0] BAD_OPS [4] = '{6'h1c, 6'h33, 6'h02, 6'h23};  // SPECIAL2, pref, j, lw

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    reg_write_t  ex_fwd;
    reg_write_t  mem_fwd;
    reg_write_t  wb;
    id_ex_t      id_ex;

    logic [31:0] lfsr = 32'h9d06;
    word_t       model_regs [NUM_REGS];
    int unsigned ctrl_errors = 0;
    int unsigned word_errors = 0;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_unit_top decode_unit_top_inst (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .inst_i    (inst),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .wb_i      (wb),
        .id_ex_o   (id_ex)
    );

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm16;
        logic [3:0]  kind;
        rs    = rand_bits(5);
        rt    = rand_bits(5);
        rd    = rand_bits(5);
        sa    = rand_bits(5);
        imm16 = rand_bits(16);
        kind  = rand_bits(4);
        case (kind)
            0, 1, 2, 3, 4, 5: return {OP_SPECIAL, rs, rt, rd, 5'd0, REG_FUNCTS[rand_bits(4) % 13]};
            6, 7:             return {OP_SPECIAL, 5'd0, rt, rd, sa, SHIFT_FUNCTS[rand_bits(2) % 3]};
            8, 9, 10, 11:     return {IMM_OPS[rand_bits(3)], rs, rt, imm16};
            12:               return {OP_SPECIAL, rs, rt, rd, sa, BAD_FUNCTS[rand_bits(3) % 6]};
            13:               return {BAD_OPS[rand_bits(2)], rs, rt, imm16};
            14:               return {OP_SPECIAL, rs, rt, rd, sa, 4'b0000, imm16[1:0]};
            default:          return {rs, rt, rd, sa, imm16[11:0]};
        endcase
    endfunction

    // EX, then MEM, then register file, else immediate
    function automatic word_t resolve(logic re, reg_addr_t a, word_t imm);
        if (!re)
            return imm;
        else if (ex_fwd.we && (ex_fwd.addr == a))
            return ex_fwd.data;
        else if (mem_fwd.we && (mem_fwd.addr == a))
            return mem_fwd.data;
        else if (a == '0)
            return '0;
        else if (wb.we && (wb.addr == a))
            return wb.data;                 // same-cycle write-back
        return model_regs[a];
    endfunction

    function automatic id_ex_t expect_id_ex(logic [31:0] i);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm16;
        logic        shift_imm;
        logic        valid;
        aluop_t      spec_op;
        word_t       imm;
        id_ex_t      e;
        op        = i[OPCODE_MSB:OPCODE_LSB];
        fn        = i[FUNCT_MSB:FUNCT_LSB];
        imm16     = i[IMM_MSB:IMM_LSB];
        shift_imm = fn inside {FN_SLL, FN_SRL, FN_SRA};
        case (fn)
            FN_SLL, FN_SLLV: spec_op = ALU_SLL;
            FN_SRL, FN_SRLV: spec_op = ALU_SRL;
            FN_SRA, FN_SRAV: spec_op = ALU_SRA;
            FN_OR:           spec_op = ALU_OR;
            FN_AND:          spec_op = ALU_AND;
            FN_XOR:          spec_op = ALU_XOR;
            FN_NOR:          spec_op = ALU_NOR;
            FN_ADD:          spec_op = ALU_ADD;
            FN_ADDU:         spec_op = ALU_ADDU;
            FN_SUB:          spec_op = ALU_SUB;
            FN_SUBU:         spec_op = ALU_SUBU;
            FN_SLT:          spec_op = ALU_SLT;
            FN_SLTU:         spec_op = ALU_SLTU;
            default:         spec_op = ALU_NOP;
        endcase
        // shamt forms need rs zero and register forms need shamt zero
        if (shift_imm ? (i[RS_MSB:RS_LSB] != '0) : (i[SHAMT_MSB:SHAMT_LSB] != '0))
            spec_op = ALU_NOP;
        case (op)
            OP_SPECIAL:     e.ctrl.aluop = spec_op;
            OP_ORI, OP_LUI: e.ctrl.aluop = ALU_OR;
            OP_ANDI:        e.ctrl.aluop = ALU_AND;
            OP_XORI:        e.ctrl.aluop = ALU_XOR;
            OP_ADDI:        e.ctrl.aluop = ALU_ADDI;
            OP_ADDIU:       e.ctrl.aluop = ALU_ADDIU;
            OP_SLTI:        e.ctrl.aluop = ALU_SLT;
            OP_SLTIU:       e.ctrl.aluop = ALU_SLTU;
            default:        e.ctrl.aluop = ALU_NOP;
        endcase
        case (e.ctrl.aluop)
            ALU_NOP:                           e.ctrl.alusel = SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: e.ctrl.alusel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         e.ctrl.alusel = SEL_SHIFT;
            default:                           e.ctrl.alusel = SEL_ARITH;
        endcase
        valid = (e.ctrl.aluop != ALU_NOP);
        if (!valid)
            imm = '0;
        else if (op == OP_SPECIAL)
            imm = shift_imm ? {27'b0, i[SHAMT_MSB:SHAMT_LSB]} : '0;
        else if (op == OP_LUI)
            imm = {imm16, 16'b0};
        else if (op inside {OP_ORI, OP_ANDI, OP_XORI})
            imm = {16'b0, imm16};
        else
            imm = {{16{imm16[15]}}, imm16};
        e.ctrl.wd         = (valid && (op != OP_SPECIAL)) ? i[RT_MSB:RT_LSB] : i[RD_MSB:RD_LSB];
        e.ctrl.wreg       = valid;
        e.ctrl.inst_valid = valid;
        e.reg1 = resolve(valid && !((op == OP_SPECIAL) && shift_imm), i[RS_MSB:RS_LSB], imm);
        e.reg2 = resolve(valid && (op == OP_SPECIAL), i[RT_MSB:RT_LSB], imm);
        return e;
    endfunction

    task automatic drive_inputs();
        reg_addr_t rs;
        reg_addr_t rt;
        logic      fwd_on;
        inst         = make_inst();
        rs           = inst[RS_MSB:RS_LSB];
        rt           = inst[RT_MSB:RT_LSB];
        fwd_on       = (rand_bits(2) != 0);    // one cycle in four without forwards
        ex_fwd.we    = rand_bits(1) && fwd_on;
        ex_fwd.addr  = rand_bits(1) ? (rand_bits(1) ? rs : rt) : reg_addr_t'(rand_bits(5));
        ex_fwd.data  = rand_bits(32);
        mem_fwd.we   = rand_bits(1) && fwd_on;
        mem_fwd.addr = rand_bits(1) ? (rand_bits(1) ? rs : rt) : reg_addr_t'(rand_bits(5));
        mem_fwd.data = rand_bits(32);
        wb.we        = rand_bits(1);
        wb.addr      = rand_bits(1) ? (rand_bits(1) ? rs : rt) : reg_addr_t'(rand_bits(5));
        wb.data      = rand_bits(32);
    endtask

    task automatic compare_ctrl(id_ctrl_t got, id_ctrl_t exp, string what);
        if (got !== exp) begin
            ctrl_errors++;
            $display("FAILED %0t: %s ctrl got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            word_errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        #((RESET_CYCLES + NUM_TESTS * 3 + 20) * PERIOD_NS);
        $display("watchdog expired before all decode tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        id_ex_t      exp;
        logic [31:0] exp_inst;
        int unsigned chk_errors;
        inst    = '0;
        ex_fwd  = '0;
        mem_fwd = '0;
        wb      = '0;
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        wait (rst_n === 1'b1);
        compare_ctrl(id_ex.ctrl, '0, "after reset");
        compare_word(id_ex.reg1, '0, "after reset operand 1");
        compare_word(id_ex.reg2, '0, "after reset operand 2");
        for (int n = 0; n <= NUM_TESTS; n++) begin
            @(negedge clk);
            if (n > 0) begin
                compare_ctrl(id_ex.ctrl, exp.ctrl, $sformatf("inst %h", exp_inst));
                compare_word(id_ex.reg1, exp.reg1, $sformatf("inst %h operand 1", exp_inst));
                compare_word(id_ex.reg2, exp.reg2, $sformatf("inst %h operand 2", exp_inst));
            end
            if (n < NUM_TESTS) begin
                drive_inputs();
                exp      = expect_id_ex(inst);
                exp_inst = inst;
                if (wb.we && (wb.addr != '0)) begin
                    model_regs[wb.addr] = wb.data;
                end
            end
        end
        chk_errors = decode_unit_top_inst.id_stage_inst.decode_unit_chk_inst.fail_count;
        $display("errors: ctrl %0d, operand %0d, assertion %0d",
                 ctrl_errors, word_errors, chk_errors);
        if (ctrl_errors + word_errors + chk_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/mips_isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/id_decoder.sv
design/operand_select.sv
design/id_stage.sv
design/decode_unit_top.sv
tests/tb_clk_gen.sv
tests/decode_unit_chk.sv
tests/tb_decode_unit.sv
